/* controllerTb.sv */
module controllerTb;

    localparam int AddrWidth  = 4;
    localparam int CountWidth = 8;
    localparam int CountMax   = (1 << CountWidth) - 1;
    localparam int NumXfers   = 3 + 30 * 3 + 40 * 2 + 1 + 300 + 2 + 9;
    localparam int CycleLimit = NumXfers * 3 + 50;

    localparam logic [AddrWidth-1:0] AddrInstr = AddrWidth'(ctrlPkg::RegInstr);
    localparam logic [AddrWidth-1:0] AddrCtrl  = AddrWidth'(ctrlPkg::RegCtrl);
    localparam logic [AddrWidth-1:0] AddrUndef = AddrWidth'(ctrlPkg::RegUndef);

    logic                 clk;
    logic                 arstN;
    logic                 psel;
    logic                 penable;
    logic                 pwrite;
    logic [AddrWidth-1:0] paddr;
    logic [31:0]          pwdata;
    logic [31:0]          prdata;
    logic                 pready;
    logic                 pslverr;

    integer      seed;
    int          cycles = 0;
    int          nDefined;
    logic [31:0] expInstr;
    logic [31:0] expCtrl;
    int          expUndef;
    logic [31:0] ins;
    logic [31:0] r;
    logic [31:0] rd;
    logic        err;
    logic [5:0]  op;
    logic [5:0]  sel;
    logic        pick;
    logic [ctrlPkg::CtrlWidth:0] m;
    logic [AddrWidth-1:0]        addr;

    tbClock #(.Period(100), .ResetCycles(2)) clock0 (.clk(clk), .arstN(arstN));

    controllerTop #(
        .AddrWidth (AddrWidth),
        .CountWidth(CountWidth)
    ) dut0 (
        .clk    (clk),
        .arstN  (arstN),
        .psel   (psel),
        .penable(penable),
        .pwrite (pwrite),
        .paddr  (paddr),
        .pwdata (pwdata),
        .prdata (prdata),
        .pready (pready),
        .pslverr(pslverr)
    );

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CycleLimit) begin
            $display("timeout: no end of test after %0d clock cycles", cycles);
            $display("SIMULATION FAILED");
            $fatal(1, "run stopped by the cycle limit");
        end
    end

    task automatic checkEq(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("error: time %0t signal %s got %h expected %h", $time, name, got, exp);
            $display("SIMULATION FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // reference model of the decode tables
    ////////////////////////////////////////////////////////////
    // returns {known, control word}
    function automatic logic [ctrlPkg::CtrlWidth:0] modelDecode(input logic [31:0] word);
        logic [5:0] opc;
        logic [5:0] fn;
        logic [4:0] rt;
        logic [5:0] alu;
        logic [5:0] flags; // regWrite memWrite memRead memToReg regDst aluSrc
        logic [3:0] tail;  // jrAddress jrData rType shiftMux
        logic [1:0] ld;
        logic [1:0] sd;
        logic [1:0] jm;
        logic       pc;
        logic       known;
        logic [ctrlPkg::CtrlWidth-1:0] w;
        opc = word[31:26];
        fn = word[5:0];
        rt = word[20:16];
        alu = opc;
        flags = '0;
        tail = '0;
        ld = '0;
        sd = '0;
        jm = '0;
        pc = 1'b0;
        known = 1'b1;
        case (opc)
            6'h00: begin
                alu = fn;
                tail = 4'b0010;
                if (fn inside {6'h20, 6'h22, 6'h24, 6'h25, 6'h26, 6'h27, 6'h2a}) begin
                    flags = 6'b100110;
                end else if (fn == 6'h00 || fn == 6'h02) begin // sll, srl
                    flags = 6'b100110;
                    tail = 4'b0011;
                end else if (fn == 6'h08) begin // jr
                    pc = 1'b1;
                    jm = 2'd1;
                    tail = 4'b1110;
                end else begin
                    known = 1'b0;
                end
            end
            6'h01: begin // bltz, bgez
                alu = {1'b0, rt};
                pc = 1'b1;
                known = rt < 5'd2;
            end
            6'h1c: begin // mul
                flags = 6'b100110;
                known = fn == 6'h02;
            end
            6'h02, 6'h03: begin // j, jal
                pc = 1'b1;
                jm = 2'd2;
                if (opc == 6'h03) begin
                    flags = 6'b100000;
                    tail = 4'b1100;
                end
            end
            6'h08, 6'h0a, 6'h0c, 6'h0d, 6'h0e: flags = 6'b100101;
            6'h20, 6'h21, 6'h23: begin
                flags = 6'b101001;
                ld = (opc == 6'h23) ? 2'd0 : (opc == 6'h21) ? 2'd1 : 2'd2;
            end
            6'h28, 6'h29, 6'h2b: begin
                flags = 6'b010001;
                sd = (opc == 6'h2b) ? 2'd0 : (opc == 6'h29) ? 2'd1 : 2'd2;
            end
            6'h04, 6'h05, 6'h06, 6'h07: pc = 1'b1;
            default: known = 1'b0;
        endcase
        w = '0;
        if (known) begin
            w[ctrlPkg::AluOpLsb +: 6] = alu;
            w[ctrlPkg::RegWriteBit] = flags[5];
            w[ctrlPkg::MemWriteBit] = flags[4];
            w[ctrlPkg::MemReadBit] = flags[3];
            w[ctrlPkg::MemToRegBit] = flags[2];
            w[ctrlPkg::RegDstBit] = flags[1];
            w[ctrlPkg::AluSrcBit] = flags[0];
            w[ctrlPkg::LoadDataLsb +: 2] = ld;
            w[ctrlPkg::PcSrcBit] = pc;
            w[ctrlPkg::StoreDataLsb +: 2] = sd;
            w[ctrlPkg::JmuxLsb +: 2] = jm;
            w[ctrlPkg::JrAddressBit] = tail[3];
            w[ctrlPkg::JrDataBit] = tail[2];
            w[ctrlPkg::RTypeBit] = tail[1];
            w[ctrlPkg::ShiftMuxBit] = tail[0];
        end else begin
            w[ctrlPkg::AluOpLsb +: 6] = '1; // bubble
            w[ctrlPkg::RTypeBit] = opc == 6'h00;
        end
        return {known, w};
    endfunction

    ////////////////////////////////////////////////////////////
    // apb transfers
    ////////////////////////////////////////////////////////////
    task automatic apbXfer(input logic wr, input logic [AddrWidth-1:0] a,
                           input logic [31:0] wdata, output logic [31:0] rdata,
                           output logic slvErr);
        @(posedge clk);
        #10;
        psel = 1'b1; // setup phase
        penable = 1'b0;
        pwrite = wr;
        paddr = a;
        pwdata = wdata;
        @(posedge clk);
        #10;
        penable = 1'b1;
        @(negedge clk); // mid access cycle
        rdata = prdata;
        slvErr = pslverr;
        checkEq("pready", {31'b0, pready}, 32'd1);
        @(posedge clk);
        #10;
        psel = 1'b0;
        penable = 1'b0;
    endtask

    task automatic writeInstr(input logic [31:0] word);
        logic [31:0] rdata;
        logic        slvErr;
        logic [ctrlPkg::CtrlWidth:0] res;
        apbXfer(1'b1, AddrInstr, word, rdata, slvErr);
        checkEq("pslverr", {31'b0, slvErr}, 32'd0);
        res = modelDecode(word);
        expInstr = word;
        expCtrl = {9'b0, res[ctrlPkg::CtrlWidth-1:0]};
        if (!res[ctrlPkg::CtrlWidth] && expUndef < CountMax) begin
            expUndef++;
        end
    endtask

    task automatic readExpect(input logic [AddrWidth-1:0] a, input logic [31:0] exp,
                              input string name);
        logic [31:0] rdata;
        logic        slvErr;
        apbXfer(1'b0, a, 32'd0, rdata, slvErr);
        checkEq("pslverr", {31'b0, slvErr}, 32'd0);
        checkEq(name, rdata, exp);
    endtask

    // cat 0 any opcode outside the groups, 1 SPECIAL, 2 REGIMM, 3 SPECIAL2
    task automatic pickUndefined(input int cat, output logic [31:0] word);
        logic [ctrlPkg::CtrlWidth:0] res;
        do begin
            word = $random(seed);
            case (cat)
                1: word[31:26] = 6'h00;
                2: word[31:26] = 6'h01;
                3: word[31:26] = 6'h1c;
                default: ;
            endcase
            res = modelDecode(word);
        end while (res[ctrlPkg::CtrlWidth] ||
                   (cat == 0 && word[31:26] inside {6'h00, 6'h01, 6'h1c}));
    endtask

    task automatic pickUnmapped(output logic [AddrWidth-1:0] a);
        logic [31:0] rnd;
        do begin
            rnd = $random(seed);
            a = rnd[AddrWidth-1:0];
        end while (a == AddrInstr || a == AddrCtrl || a == AddrUndef);
    endtask

    initial begin
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = '0;
        pwdata = '0;
        seed = 32'h1306793d;
        expInstr = '0;
        expCtrl = '0;
        expUndef = 0;
        nDefined = 0;
        @(posedge arstN);

        readExpect(AddrInstr, 32'd0, "prdata RegInstr");
        readExpect(AddrCtrl, 32'd0, "prdata RegCtrl");
        readExpect(AddrUndef, 32'd0, "prdata RegUndef");

        // sweep opcode and funct/rt, keep what the model calls defined
        for (int k = 0; k < 4096; k++) begin
            op = k[11:6];
            sel = k[5:0];
            ins = $random(seed);
            ins[31:26] = op;
            if (op == 6'h01) begin
                ins[20:16] = sel[4:0];
            end else begin
                ins[5:0] = sel;
            end
            if (op == 6'h00 || op == 6'h1c) begin
                pick = 1'b1;
            end else if (op == 6'h01) begin
                pick = sel < 6'd32;
            end else begin
                pick = sel == 6'd0;
            end
            m = modelDecode(ins);
            if (pick && m[ctrlPkg::CtrlWidth]) begin
                nDefined++;
                writeInstr(ins);
                readExpect(AddrCtrl, expCtrl, "prdata RegCtrl");
                readExpect(AddrInstr, ins, "prdata RegInstr");
            end
        end
        checkEq("defined instruction count", nDefined, 30);

        for (int i = 0; i < 40; i++) begin
            pickUndefined(i % 4, ins);
            writeInstr(ins);
            readExpect(AddrCtrl, expCtrl, "prdata RegCtrl bubble");
        end
        readExpect(AddrUndef, expUndef, "prdata RegUndef");

        // mixed writes, biased toward undefined so the count saturates
        for (int i = 0; i < 300; i++) begin
            r = $random(seed);
            if (r[0]) begin
                pickUndefined(int'(r[2:1]), ins);
            end else begin
                ins = $random(seed);
            end
            writeInstr(ins);
        end
        readExpect(AddrUndef, expUndef, "prdata RegUndef");
        readExpect(AddrCtrl, expCtrl, "prdata RegCtrl");

        ////////////////////////////////////////////////////////////
        // slave errors
        ////////////////////////////////////////////////////////////
        r = $random(seed);
        apbXfer(1'b1, AddrCtrl, r, rd, err);
        checkEq("pslverr write RegCtrl", {31'b0, err}, 32'd1);
        r = $random(seed);
        apbXfer(1'b1, AddrUndef, r, rd, err);
        checkEq("pslverr write RegUndef", {31'b0, err}, 32'd1);
        pickUnmapped(addr);
        r = $random(seed);
        apbXfer(1'b1, addr, r, rd, err);
        checkEq("pslverr unmapped write", {31'b0, err}, 32'd1);
        repeat (3) begin
            pickUnmapped(addr);
            apbXfer(1'b0, addr, 32'd0, rd, err);
            checkEq("pslverr unmapped read", {31'b0, err}, 32'd1);
            checkEq("prdata unmapped read", rd, 32'd0);
        end
        readExpect(AddrInstr, expInstr, "prdata RegInstr");
        readExpect(AddrCtrl, expCtrl, "prdata RegCtrl");
        readExpect(AddrUndef, expUndef, "prdata RegUndef");

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

/* controllerTop.sv */
module controllerTop #(
    parameter int AddrWidth  = 4,
    parameter int CountWidth = 8
) (
    input  logic                           clk,
    input  logic                           arstN,
    input  logic                           psel,
    input  logic                           penable,
    input  logic                           pwrite,
    input  logic [AddrWidth-1:0]           paddr,
    input  logic [ctrlPkg::InstrWidth-1:0] pwdata,
    output logic [ctrlPkg::InstrWidth-1:0] prdata,
    output logic                           pready,
    output logic                           pslverr
);

    ctrlPkg::instrWordT            instr;
    logic                          instrLoad;
    logic [ctrlPkg::CtrlWidth-1:0] specialWord;
    logic                          specialOwns;
    logic                          specialKnown;
    logic [ctrlPkg::CtrlWidth-1:0] mainWord;
    logic                          mainKnown;
    logic [ctrlPkg::CtrlWidth-1:0] ctrlWord;
    logic [CountWidth-1:0]         undefCount;

    ctrlApbSlave #(
        .AddrWidth (AddrWidth),
        .CountWidth(CountWidth)
    ) apb0 (
        .clk       (clk),
        .arstN     (arstN),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .ctrlWord  (ctrlWord),
        .undefCount(undefCount),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .instr     (instr),
        .instrLoad (instrLoad)
    );

    specialDecoder special0 (
        .instr       (instr),
        .specialWord (specialWord),
        .specialOwns (specialOwns),
        .specialKnown(specialKnown)
    );

    mainDecoder main0 (
        .instr    (instr),
        .mainWord (mainWord),
        .mainKnown(mainKnown)
    );

    ctrlResolve #(
        .CountWidth(CountWidth)
    ) resolve0 (
        .clk         (clk),
        .arstN       (arstN),
        .specialWord (specialWord),
        .specialOwns (specialOwns),
        .specialKnown(specialKnown),
        .mainWord    (mainWord),
        .mainKnown   (mainKnown),
        .instrLoad   (instrLoad),
        .ctrlWord    (ctrlWord),
        .undefCount  (undefCount)
    );

endmodule

/* ctrlApbSlave.sv */
module ctrlApbSlave #(
    parameter int AddrWidth  = 4,
    parameter int CountWidth = 8
) (
    input  logic                           clk,
    input  logic                           arstN,
    input  logic                           psel,
    input  logic                           penable,
    input  logic                           pwrite,
    input  logic [AddrWidth-1:0]           paddr,
    input  logic [ctrlPkg::InstrWidth-1:0] pwdata,
    input  logic [ctrlPkg::CtrlWidth-1:0]  ctrlWord,
    input  logic [CountWidth-1:0]          undefCount,
    output logic [ctrlPkg::InstrWidth-1:0] prdata,
    output logic                           pready,
    output logic                           pslverr,
    output ctrlPkg::instrWordT             instr,
    output logic                           instrLoad
);

    logic       setup;
    logic       access;
    logic       isInstr;
    logic       isCtrl;
    logic       isUndef;
    logic       badXfer;
    logic [2:0] rdSel; // one-hot {undef, ctrl, instr}

    assign setup   = psel && !penable;
    assign access  = psel && penable;
    assign isInstr = paddr == AddrWidth'(ctrlPkg::RegInstr);
    assign isCtrl  = paddr == AddrWidth'(ctrlPkg::RegCtrl);
    assign isUndef = paddr == AddrWidth'(ctrlPkg::RegUndef);
    assign badXfer = !(isInstr || isCtrl || isUndef) || (pwrite && !isInstr);

    assign pready = 1'b1; // no wait states

    ////////////////////////////////////////////////////////////
    // register block
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            instr     <= '0;
            instrLoad <= 1'b0;
            rdSel     <= '0;
            pslverr   <= 1'b0;
        end else begin
            instrLoad <= access && pwrite && isInstr;
            if (access && pwrite && isInstr) begin
                instr <= pwdata;
            end
            if (setup) begin // decode held through the access cycle
                rdSel   <= pwrite ? 3'b000 : {isUndef, isCtrl, isInstr};
                pslverr <= badXfer;
            end else begin
                rdSel   <= '0;
                pslverr <= 1'b0;
            end
        end
    end

    // live data so a read right after a write sees the new word
    always_comb begin
        prdata = '0;
        if (rdSel[0]) prdata = instr;
        if (rdSel[1]) prdata = ctrlPkg::InstrWidth'(ctrlWord);
        if (rdSel[2]) prdata = ctrlPkg::InstrWidth'(undefCount);
    end

    assert property (@(posedge clk) disable iff (!arstN) penable |-> psel);

endmodule

/* ctrlPkg.sv */
package ctrlPkg;

    ////////////////////////////////////////////////////////////
    // widths and control word layout
    ////////////////////////////////////////////////////////////
    localparam int InstrWidth = 32;
    localparam int CtrlWidth  = 23;
    localparam int AluOpWidth = 6;

    localparam int AluOpLsb     = 17; // 6 bits, 22:17
    localparam int RegWriteBit  = 16;
    localparam int MemWriteBit  = 15;
    localparam int MemReadBit   = 14;
    localparam int MemToRegBit  = 13;
    localparam int RegDstBit    = 12;
    localparam int AluSrcBit    = 11;
    localparam int LoadDataLsb  = 9;  // 2 bits
    localparam int PcSrcBit     = 8;
    localparam int StoreDataLsb = 6;  // 2 bits
    localparam int JmuxLsb      = 4;  // 2 bits
    localparam int JrAddressBit = 3;
    localparam int JrDataBit    = 2;
    localparam int RTypeBit     = 1;
    localparam int ShiftMuxBit  = 0;

    // alu op all ones, every other field clear
    localparam logic [CtrlWidth-1:0] BubbleWord = CtrlWidth'(6'h3F) << AluOpLsb;

    ////////////////////////////////////////////////////////////
    // opcode, funct and rt codes
    ////////////////////////////////////////////////////////////
    localparam logic [5:0] OpSpecial  = 6'b000_000;
    localparam logic [5:0] OpRegimm   = 6'b000_001;
    localparam logic [5:0] OpSpecial2 = 6'b011_100;
    localparam logic [5:0] OpJ        = 6'b000_010;
    localparam logic [5:0] OpJal      = 6'b000_011;
    localparam logic [5:0] OpBeq      = 6'b000_100;
    localparam logic [5:0] OpBne      = 6'b000_101;
    localparam logic [5:0] OpBlez     = 6'b000_110;
    localparam logic [5:0] OpBgtz     = 6'b000_111;
    localparam logic [5:0] OpAddi     = 6'b001_000;
    localparam logic [5:0] OpSlti     = 6'b001_010;
    localparam logic [5:0] OpAndi     = 6'b001_100;
    localparam logic [5:0] OpOri      = 6'b001_101;
    localparam logic [5:0] OpXori     = 6'b001_110;
    localparam logic [5:0] OpLb       = 6'b100_000;
    localparam logic [5:0] OpLh       = 6'b100_001;
    localparam logic [5:0] OpLw       = 6'b100_011;
    localparam logic [5:0] OpSb       = 6'b101_000;
    localparam logic [5:0] OpSh       = 6'b101_001;
    localparam logic [5:0] OpSw       = 6'b101_011;

    localparam logic [5:0] FnSll = 6'b000_000;
    localparam logic [5:0] FnSrl = 6'b000_010;
    localparam logic [5:0] FnJr  = 6'b001_000;
    localparam logic [5:0] FnAdd = 6'b100_000;
    localparam logic [5:0] FnSub = 6'b100_010;
    localparam logic [5:0] FnAnd = 6'b100_100;
    localparam logic [5:0] FnOr  = 6'b100_101;
    localparam logic [5:0] FnXor = 6'b100_110;
    localparam logic [5:0] FnNor = 6'b100_111;
    localparam logic [5:0] FnSlt = 6'b101_010;
    localparam logic [5:0] FnMul = 6'b000_010; // under SPECIAL2

    localparam logic [4:0] RtBltz = 5'b00000;
    localparam logic [4:0] RtBgez = 5'b00001;

    // apb register offsets
    localparam int unsigned RegInstr = 'h0;
    localparam int unsigned RegCtrl  = 'h4;
    localparam int unsigned RegUndef = 'h8;

    typedef union packed {
        struct packed {
            logic [5:0] opcode;
            logic [4:0] rs;
            logic [4:0] rt;
            logic [4:0] rd;
            logic [4:0] shamt;
            logic [5:0] funct;
        } rFields;
        struct packed {
            logic [5:0]  opcode;
            logic [4:0]  rs;
            logic [4:0]  rt;
            logic [15:0] imm;
        } iFields;
    } instrWordT;

    // flags: regWrite memWrite memRead memToReg regDst aluSrc
    // tail: jrAddress jrData rType shiftMux
    function automatic logic [CtrlWidth-1:0] packCtrl(
        input logic [AluOpWidth-1:0] aluOp,
        input logic [5:0]            flags,
        input logic [1:0]            loadData,
        input logic                  pcSrc,
        input logic [1:0]            storeData,
        input logic [1:0]            jmux,
        input logic [3:0]            tail
    );
        logic [CtrlWidth-1:0] w;
        w = '0;
        w[AluOpLsb +: AluOpWidth] = aluOp;
        w[RegWriteBit]            = flags[5];
        w[MemWriteBit]            = flags[4];
        w[MemReadBit]             = flags[3];
        w[MemToRegBit]            = flags[2];
        w[RegDstBit]              = flags[1];
        w[AluSrcBit]              = flags[0];
        w[LoadDataLsb +: 2]       = loadData;
        w[PcSrcBit]               = pcSrc;
        w[StoreDataLsb +: 2]      = storeData;
        w[JmuxLsb +: 2]           = jmux;
        w[JrAddressBit]           = tail[3];
        w[JrDataBit]              = tail[2];
        w[RTypeBit]               = tail[1];
        w[ShiftMuxBit]            = tail[0];
        return w;
    endfunction

endpackage

/* ctrlResolve.sv */
module ctrlResolve #(
    parameter int CountWidth = 8
) (
    input  logic                          clk,
    input  logic                          arstN,
    input  logic [ctrlPkg::CtrlWidth-1:0] specialWord,
    input  logic                          specialOwns,
    input  logic                          specialKnown,
    input  logic [ctrlPkg::CtrlWidth-1:0] mainWord,
    input  logic                          mainKnown,
    input  logic                          instrLoad,
    output logic [ctrlPkg::CtrlWidth-1:0] ctrlWord,
    output logic [CountWidth-1:0]         undefCount
);

    logic [ctrlPkg::CtrlWidth-1:0] chosenWord;
    logic                          chosenKnown;

    assign chosenWord  = specialOwns ? specialWord : mainWord;
    assign chosenKnown = specialOwns ? specialKnown : mainKnown;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            ctrlWord   <= '0;
            undefCount <= '0;
        end else if (instrLoad) begin // word of the newly written instruction
            ctrlWord <= chosenWord;
            if (!chosenKnown && undefCount != '1) begin
                undefCount <= undefCount + 1'b1; // saturating
            end
        end
    end

    // a bubble from either decoder never writes the register file or memory
    assert property (@(posedge clk) disable iff (!arstN)
        (ctrlWord[ctrlPkg::AluOpLsb +: ctrlPkg::AluOpWidth] == '1) |->
            !ctrlWord[ctrlPkg::RegWriteBit] && !ctrlWord[ctrlPkg::MemWriteBit]);

    assert property (@(posedge clk) disable iff (!arstN)
        undefCount >= $past(undefCount));

endmodule

/* flist.f */
ctrlPkg.sv
specialDecoder.sv
mainDecoder.sv
ctrlResolve.sv
ctrlApbSlave.sv
controllerTop.sv
tbClock.sv
controllerTb.sv

/* mainDecoder.sv */
module mainDecoder (
    input  ctrlPkg::instrWordT             instr,
    output logic [ctrlPkg::CtrlWidth-1:0] mainWord,
    output logic                          mainKnown
);

    logic [5:0] op;

    assign op = instr.iFields.opcode;

    // alu op is the opcode itself for every entry here
    always_comb begin
        mainKnown = 1'b1;
        mainWord  = ctrlPkg::BubbleWord;
        case (op)
            ctrlPkg::OpJal: begin // link through jr data path
                mainWord = ctrlPkg::packCtrl(op, 6'b100000, 2'd0, 1'b1,
                                             2'd0, 2'd2, 4'b1100);
            end
            ctrlPkg::OpJ: begin
                mainWord = ctrlPkg::packCtrl(op, 6'b000000, 2'd0, 1'b1,
                                             2'd0, 2'd2, 4'b0000);
            end
            ctrlPkg::OpAddi, ctrlPkg::OpAndi, ctrlPkg::OpOri,
            ctrlPkg::OpXori, ctrlPkg::OpSlti: begin
                mainWord = ctrlPkg::packCtrl(op, 6'b100101, 2'd0, 1'b0,
                                             2'd0, 2'd0, 4'b0000);
            end

            ////////////////////////////////////////////////////////////
            // loads and stores
            ////////////////////////////////////////////////////////////
            ctrlPkg::OpLw: begin
                mainWord = ctrlPkg::packCtrl(op, 6'b101001, 2'd0, 1'b0,
                                             2'd0, 2'd0, 4'b0000);
            end
            ctrlPkg::OpLh: begin // half word load
                mainWord = ctrlPkg::packCtrl(op, 6'b101001, 2'd1, 1'b0,
                                             2'd0, 2'd0, 4'b0000);
            end
            ctrlPkg::OpLb: begin // byte load
                mainWord = ctrlPkg::packCtrl(op, 6'b101001, 2'd2, 1'b0,
                                             2'd0, 2'd0, 4'b0000);
            end
            ctrlPkg::OpSw: begin
                mainWord = ctrlPkg::packCtrl(op, 6'b010001, 2'd0, 1'b0,
                                             2'd0, 2'd0, 4'b0000);
            end
            ctrlPkg::OpSh: begin
                mainWord = ctrlPkg::packCtrl(op, 6'b010001, 2'd0, 1'b0,
                                             2'd1, 2'd0, 4'b0000);
            end
            ctrlPkg::OpSb: begin
                mainWord = ctrlPkg::packCtrl(op, 6'b010001, 2'd0, 1'b0,
                                             2'd2, 2'd0, 4'b0000);
            end

            ctrlPkg::OpBeq, ctrlPkg::OpBne,
            ctrlPkg::OpBgtz, ctrlPkg::OpBlez: begin // compare in alu
                mainWord = ctrlPkg::packCtrl(op, 6'b000000, 2'd0, 1'b1,
                                             2'd0, 2'd0, 4'b0000);
            end
            default: mainKnown = 1'b0;
        endcase
    end

endmodule

/* run.sh */
#!/bin/sh
# Compile and run the controller testbench with Verilator.
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal \
    --top-module controllerTb -Mdir obj_dir -o simv \
    -f flist.f

# the simulator exit status is not trusted, the log decides
./obj_dir/simv | tee sim.log

if grep -q "SIMULATION PASSED" sim.log; then
    echo "run.sh: test passed"
    exit 0
else
    echo "run.sh: test failed, see sim.log"
    exit 1
fi

/* specialDecoder.sv */
module specialDecoder (
    input  ctrlPkg::instrWordT             instr,
    output logic [ctrlPkg::CtrlWidth-1:0] specialWord,
    output logic                          specialOwns,
    output logic                          specialKnown
);

    logic [5:0] opcode;
    logic [5:0] funct;
    logic [4:0] rt;

    assign opcode = instr.rFields.opcode;
    assign funct  = instr.rFields.funct;
    assign rt     = instr.rFields.rt;

    ////////////////////////////////////////////////////////////
    // SPECIAL, REGIMM and SPECIAL2 groups
    ////////////////////////////////////////////////////////////
    always_comb begin
        specialOwns  = 1'b1;
        specialKnown = 1'b1;
        specialWord  = ctrlPkg::BubbleWord;
        case (opcode)
            ctrlPkg::OpSpecial: begin
                case (funct)
                    ctrlPkg::FnAdd, ctrlPkg::FnSub, ctrlPkg::FnAnd, ctrlPkg::FnOr,
                    ctrlPkg::FnNor, ctrlPkg::FnXor, ctrlPkg::FnSlt: begin
                        specialWord = ctrlPkg::packCtrl(funct, 6'b100110, 2'd0, 1'b0,
                                                        2'd0, 2'd0, 4'b0010);
                    end
                    ctrlPkg::FnSll, ctrlPkg::FnSrl: begin // shamt path
                        specialWord = ctrlPkg::packCtrl(funct, 6'b100110, 2'd0, 1'b0,
                                                        2'd0, 2'd0, 4'b0011);
                    end
                    ctrlPkg::FnJr: begin
                        specialWord = ctrlPkg::packCtrl(funct, 6'b000000, 2'd0, 1'b1,
                                                        2'd0, 2'd1, 4'b1110);
                    end
                    default: begin
                        specialKnown                  = 1'b0;
                        specialWord[ctrlPkg::RTypeBit] = 1'b1; // bubble keeps rtype
                    end
                endcase
            end
            ctrlPkg::OpRegimm: begin
                case (rt)
                    ctrlPkg::RtBltz, ctrlPkg::RtBgez: begin // alu op follows rt
                        specialWord = ctrlPkg::packCtrl({1'b0, rt}, 6'b000000, 2'd0, 1'b1,
                                                        2'd0, 2'd0, 4'b0000);
                    end
                    default: specialKnown = 1'b0;
                endcase
            end
            ctrlPkg::OpSpecial2: begin
                if (funct == ctrlPkg::FnMul) begin
                    specialWord = ctrlPkg::packCtrl(6'b011_100, 6'b100110, 2'd0, 1'b0,
                                                    2'd0, 2'd0, 4'b0000);
                end else begin
                    specialKnown = 1'b0;
                end
            end
            default: begin
                specialOwns  = 1'b0;
                specialKnown = 1'b0;
            end
        endcase
    end

endmodule

/* tbClock.sv */
module tbClock #(
    parameter int Period      = 100,
    parameter int ResetCycles = 2
) (
    output logic clk,
    output logic arstN
);

    initial begin
        clk = 1'b0;
        forever #(Period / 2) clk = ~clk;
    end

    initial begin
        arstN = 1'b0;
        repeat (ResetCycles) @(posedge clk);
        #10; // release away from the edge
        arstN = 1'b1;
    end

endmodule
